/* design/sys_cfg_pkg.sv */
package sys_cfg_pkg;

	// -------------------
	// configuration fields
	// -------------------
	// mem: [1:0] chip ram size, [3:2] slow ram, [5:4] fast ram, [6] monitor enable
	typedef logic [6:0] mem_cfg_t;
	// chip: [1] ntsc, [2] a1000, [3] ecs, [4] aga
	typedef logic [4:0] chip_cfg_t;
	typedef logic [3:0] flop_cfg_t;  // floppy speed and drive count
	typedef logic [3:0] cpu_cfg_t;   // [2] fast chip, [3] fast kick

	typedef struct packed {
		mem_cfg_t  mem;
		chip_cfg_t chip;
		flop_cfg_t flop;
		cpu_cfg_t  cpu;
	} sys_cfg_t;  // 20 bits

	// bit positions used by the mode logic
	localparam int CHIP_NTSC     = 1;
	localparam int CHIP_AGA      = 4;
	localparam int CPU_FASTCHIP  = 2;
	localparam int CPU_FASTKICK  = 3;

	// -------------------
	// apb bus
	// -------------------
	typedef logic [7:0]  apb_addr_t;
	typedef logic [31:0] apb_data_t;

	typedef struct packed {
		logic      psel;
		logic      penable;
		logic      pwrite;
		apb_addr_t paddr;
		apb_data_t pwdata;
	} apb_req_t;

	typedef struct packed {
		apb_data_t prdata;
		logic      pready;
		logic      pslverr;
	} apb_rsp_t;

	// real time clock
	typedef logic [63:0] rtc_t;
	typedef logic [3:0]  nibble_t;

	// -------------------
	// register map
	// -------------------
	localparam apb_addr_t REG_MEMCFG   = 8'h00;
	localparam apb_addr_t REG_CHIPCFG  = 8'h04;
	localparam apb_addr_t REG_FLOPCFG  = 8'h08;
	localparam apb_addr_t REG_CPUCFG   = 8'h0C;
	localparam apb_addr_t REG_CTRL     = 8'h10;
	localparam apb_addr_t REG_RTC_BASE = 8'h40;  // 16 words, one nibble each

	// control word bits
	localparam int CTRL_USRRST = 0;
	localparam int CTRL_DIM_N  = 1;

endpackage

/* design/sys_timing_pkg.sv */
package sys_timing_pkg;

	// -------------------
	// audio sample rate
	// -------------------
	typedef logic [31:0] acc_t;  // fractional accumulator

	localparam acc_t SYS_CLK_HZ    = 32'd28_000_000;  // system clock
	localparam acc_t AUDIO_RATE_HZ = 32'd44_100;      // cd audio rate

	// -------------------
	// reset hold
	// -------------------
	typedef logic [1:0] hold_cnt_t;

	// frames to stay in reset once all sources are gone
	localparam int RESET_HOLD_FRAMES = 2;

	// -------------------
	// power led dimming
	// -------------------
	typedef logic [3:0] dim_cnt_t;

	localparam int LED_DIM_PERIOD = 16;  // led lit 1 cycle of 16 when dimmed

endpackage

/* design/cfg_regs.sv */
`timescale 1ns/100ps

module cfg_regs import sys_cfg_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  apb_req_t apb_req_i,
	output apb_rsp_t apb_rsp_o,
	input  rtc_t     rtc_i,
	output sys_cfg_t cfg_o,
	output logic     usrrst_o,
	output logic     dim_n_o
);

	// phase machine, one wait state per transfer
	typedef enum logic [1:0] {
		APB_IDLE,  // waiting for setup
		APB_WAIT,  // first access cycle, pready low
		APB_DONE   // second access cycle, pready high
	} apb_state_t;

	apb_state_t state_q;

	sys_cfg_t   cfg_q;   // config fields
	logic [1:0] ctrl_q;  // control word

	apb_data_t  rd_data;  // decoded read value
	logic       addr_err;  // unmapped or read-only
	logic       rtc_hit;
	nibble_t    rtc_nib;
	logic       wr_en;

	// -------------------
	// phase sequencing
	// -------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= APB_IDLE;
		end else begin
			case (state_q)
				APB_IDLE: if (apb_req_i.psel && !apb_req_i.penable) state_q <= APB_WAIT;
				APB_WAIT: begin
					if (apb_req_i.psel && apb_req_i.penable)
						state_q <= APB_DONE;
					else
						state_q <= APB_IDLE;  // master gave up
				end
				default: state_q <= APB_IDLE;  // done lasts one cycle
			endcase
		end
	end

	// -------------------
	// address decode
	// -------------------
	// rtc window is 0x40..0x7c, word aligned
	assign rtc_hit = (apb_req_i.paddr[7:6] == REG_RTC_BASE[7:6]) &&
		(apb_req_i.paddr[1:0] == 2'b00);
	assign rtc_nib = rtc_i[{apb_req_i.paddr[5:2], 2'b00} +: 4];

	always_comb begin
		rd_data  = '0;
		addr_err = 1'b0;
		if (rtc_hit) begin
			rd_data  = apb_data_t'(rtc_nib);  // zero extended
			addr_err = apb_req_i.pwrite;       // clock is read only
		end else begin
			case (apb_req_i.paddr)
				REG_MEMCFG:  rd_data = apb_data_t'(cfg_q.mem);
				REG_CHIPCFG: rd_data = apb_data_t'(cfg_q.chip);
				REG_FLOPCFG: rd_data = apb_data_t'(cfg_q.flop);
				REG_CPUCFG:  rd_data = apb_data_t'(cfg_q.cpu);
				REG_CTRL:    rd_data = apb_data_t'(ctrl_q);
				default:     addr_err = 1'b1;  // nothing here, reads zero
			endcase
		end
	end

	// -------------------
	// register writes
	// -------------------
	// commit on the last access cycle, visible the cycle after
	assign wr_en = (state_q == APB_DONE) && apb_req_i.pwrite && !addr_err;

	always_ff @(posedge clk) begin
		if (reset) begin
			cfg_q  <= '0;
			ctrl_q <= '0;
		end else if (wr_en) begin
			case (apb_req_i.paddr)
				REG_MEMCFG:  cfg_q.mem  <= apb_req_i.pwdata[6:0];
				REG_CHIPCFG: cfg_q.chip <= apb_req_i.pwdata[4:0];
				REG_FLOPCFG: cfg_q.flop <= apb_req_i.pwdata[3:0];
				REG_CPUCFG:  cfg_q.cpu  <= apb_req_i.pwdata[3:0];
				REG_CTRL:    ctrl_q     <= apb_req_i.pwdata[1:0];
				default:     ;
			endcase
		end
	end

	// response only meaningful while pready is up
	always_comb begin
		apb_rsp_o.pready  = (state_q == APB_DONE);
		apb_rsp_o.pslverr = apb_rsp_o.pready & addr_err;
		apb_rsp_o.prdata  = apb_rsp_o.pready ? rd_data : '0;
	end

	assign cfg_o    = cfg_q;
	assign usrrst_o = ctrl_q[CTRL_USRRST];  // level, held until cleared
	assign dim_n_o  = ctrl_q[CTRL_DIM_N];

endmodule

/* design/frame_sync.sv */
`timescale 1ns/100ps

module frame_sync (
	input  logic clk,
	input  logic reset,
	input  logic vsync_n_i,
	output logic sof_o,
	output logic init_b_o
);

	logic [1:0] vs_sync;  // two stage input sampler
	logic       vs_prev;  // last synced value
	logic       vs_fall;
	logic       sof_q;
	logic       init_b_q;  // toggles once per frame

	// -------------------
	// vsync edge
	// -------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			vs_sync <= 2'b11;  // idle high, no false edge
			vs_prev <= 1'b1;
		end else begin
			vs_sync <= {vs_sync[0], vsync_n_i};
			vs_prev <= vs_sync[1];
		end
	end

	assign vs_fall = vs_prev & ~vs_sync[1];  // high to low

	// frame start pulse and mcu flag
	always_ff @(posedge clk) begin
		if (reset) begin
			sof_q    <= 1'b0;
			init_b_q <= 1'b0;
		end else begin
			sof_q <= vs_fall;
			if (vs_fall)
				init_b_q <= ~init_b_q;  // osd update sync for the mcu
		end
	end

	assign sof_o    = sof_q;
	assign init_b_o = init_b_q;

endmodule

/* design/reset_seq.sv */
`timescale 1ns/100ps

module reset_seq import sys_timing_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic rst_ext_i,      // from control block
	input  logic kbd_reset_n_i,  // keyboard ctrl-amiga-amiga
	input  logic usrrst_i,       // host requested
	input  logic sof_i,          // frame start
	input  logic cpu_reset_n_i,  // cpu core reset
	output logic sys_reset_o,
	output logic cpu_reset_n_o,
	output logic rst_out_o
);

	logic      src_active;  // any reset source asserted
	logic      rst_q;
	hold_cnt_t hold_cnt;    // frames seen since release

	// -------------------
	// source merge
	// -------------------
	assign src_active = reset | rst_ext_i | ~kbd_reset_n_i | usrrst_i;

	// -------------------
	// frame counted hold
	// -------------------
	always_ff @(posedge clk) begin
		if (src_active) begin
			rst_q    <= 1'b1;  // restart the hold
			hold_cnt <= '0;
		end else if (rst_q && sof_i) begin
			if (hold_cnt == hold_cnt_t'(RESET_HOLD_FRAMES - 1)) begin
				rst_q    <= 1'b0;  // last frame, release
				hold_cnt <= '0;
			end else begin
				hold_cnt <= hold_cnt + 1'b1;
			end
		end
	end

	assign sys_reset_o   = rst_q;
	assign cpu_reset_n_o = ~rst_q;
	// system status also covers the cpu holding itself in reset
	assign rst_out_o     = rst_q | ~cpu_reset_n_i;

endmodule

/* design/audio_tick.sv */
`timescale 1ns/100ps

module audio_tick import sys_timing_pkg::*; (
	input  logic clk,
	input  logic reset,
	output logic sample_en_o
);

	acc_t acc_q;     // phase remainder, always below SYS_CLK_HZ
	acc_t acc_next;
	logic tick_q;

	// -------------------
	// fractional divider
	// -------------------
	assign acc_next = acc_q + AUDIO_RATE_HZ;

	always_ff @(posedge clk) begin
		if (reset) begin
			acc_q  <= '0;
			tick_q <= 1'b0;
		end else if (acc_next >= SYS_CLK_HZ) begin
			acc_q  <= acc_next - SYS_CLK_HZ;  // keep the fraction
			tick_q <= 1'b1;                   // one sample due
		end else begin
			acc_q  <= acc_next;
			tick_q <= 1'b0;
		end
	end

	// 44100 pulses per SYS_CLK_HZ cycles on average, no drift
	assign sample_en_o = tick_q;

endmodule

/* design/mode_flags.sv */
`timescale 1ns/100ps

module mode_flags
	import sys_cfg_pkg::*;
	import sys_timing_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       sys_reset_i,
	input  logic       ovl_i,    // kickstart overlay active
	input  logic       led_n_i,  // power led request, active low
	input  logic       dim_n_i,  // 0 dims the led when off
	input  sys_cfg_t   cfg_i,
	output logic       turbochipram_o,
	output logic       turbokick_o,
	output logic       aga_o,
	output logic       ntsc_o,
	output logic       pwr_led_o,
	output logic [1:0] slow_config_o
);

	logic     ntsc_q;
	dim_cnt_t dim_cnt;  // dim pwm phase
	logic     dim_on;   // the one lit cycle

	// -------------------
	// derived modes
	// -------------------
	// fast chip only without overlay and with full 2MB chip ram
	assign turbochipram_o = ~ovl_i & cfg_i.cpu[CPU_FASTCHIP] & (&cfg_i.mem[1:0]);
	assign turbokick_o    = ~ovl_i & cfg_i.cpu[CPU_FASTKICK];
	assign aga_o          = cfg_i.chip[CHIP_AGA];
	assign slow_config_o  = cfg_i.mem[3:2];  // slow ram size

	// video mode only changes through a reset
	always_ff @(posedge clk) begin
		if (reset)
			ntsc_q <= 1'b0;  // pal
		else if (sys_reset_i)
			ntsc_q <= cfg_i.chip[CHIP_NTSC];
	end

	assign ntsc_o = ntsc_q;

	// -------------------
	// power led
	// -------------------
	always_ff @(posedge clk) begin
		if (reset)
			dim_cnt <= '0;
		else if (dim_cnt == dim_cnt_t'(LED_DIM_PERIOD - 1))
			dim_cnt <= '0;
		else
			dim_cnt <= dim_cnt + 1'b1;
	end

	assign dim_on = (dim_cnt == '0);

	// dimmed mode glows faintly when off, full on when requested
	assign pwr_led_o = dim_n_i ? ~led_n_i : (~led_n_i | dim_on);

endmodule

/* design/minimig_sysctl.sv */
`timescale 1ns/100ps

module minimig_sysctl import sys_cfg_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       rst_ext_i,
	input  logic       kbd_reset_n_i,
	input  logic       cpu_reset_n_i,
	input  logic       vsync_n_i,
	input  logic       ovl_i,
	input  logic       led_n_i,
	input  apb_req_t   apb_req_i,
	output apb_rsp_t   apb_rsp_o,
	input  rtc_t       rtc_i,
	output sys_cfg_t   cfg_o,
	output logic       sys_reset_o,
	output logic       cpu_reset_n_o,
	output logic       rst_out_o,
	output logic       init_b_o,
	output logic       sample_en_o,
	output logic       turbochipram_o,
	output logic       turbokick_o,
	output logic       aga_o,
	output logic       ntsc_o,
	output logic       pwr_led_o,
	output logic [1:0] slow_config_o
);

	logic usrrst;  // host user reset level
	logic dim_n;
	logic sof;     // frame start pulse

	// -------------------
	// host side
	// -------------------
	cfg_regs cfg_regs_inst (
		.clk       (clk),
		.reset     (reset),
		.apb_req_i (apb_req_i),
		.apb_rsp_o (apb_rsp_o),
		.rtc_i     (rtc_i),
		.cfg_o     (cfg_o),
		.usrrst_o  (usrrst),
		.dim_n_o   (dim_n)
	);

	frame_sync frame_sync_inst (
		.clk       (clk),
		.reset     (reset),
		.vsync_n_i (vsync_n_i),
		.sof_o     (sof),
		.init_b_o  (init_b_o)
	);

	// -------------------
	// reset and modes
	// -------------------
	reset_seq reset_seq_inst (
		.clk           (clk),
		.reset         (reset),
		.rst_ext_i     (rst_ext_i),
		.kbd_reset_n_i (kbd_reset_n_i),
		.usrrst_i      (usrrst),
		.sof_i         (sof),
		.cpu_reset_n_i (cpu_reset_n_i),
		.sys_reset_o   (sys_reset_o),
		.cpu_reset_n_o (cpu_reset_n_o),
		.rst_out_o     (rst_out_o)
	);

	audio_tick audio_tick_inst (
		.clk         (clk),
		.reset       (reset),
		.sample_en_o (sample_en_o)
	);

	mode_flags mode_flags_inst (
		.clk            (clk),
		.reset          (reset),
		.sys_reset_i    (sys_reset_o),  // ntsc latched while in reset
		.ovl_i          (ovl_i),
		.led_n_i        (led_n_i),
		.dim_n_i        (dim_n),
		.cfg_i          (cfg_o),
		.turbochipram_o (turbochipram_o),
		.turbokick_o    (turbokick_o),
		.aga_o          (aga_o),
		.ntsc_o         (ntsc_o),
		.pwr_led_o      (pwr_led_o),
		.slow_config_o  (slow_config_o)
	);

endmodule

/* bench/tb_minimig_sysctl.sv */
`timescale 1ns/100ps

module tb_minimig_sysctl
	import sys_cfg_pkg::*;
	import sys_timing_pkg::*;
();

	localparam int NUM_STEPS     = 15;
	localparam int AUDIO_CYCLES  = 70000;
	localparam int APB_TIMEOUT   = 20;   // cycles to wait for pready
	localparam int RESET_TIMEOUT = 200;  // cycles to wait for sys_reset_o

	// one row of the config table
	typedef struct packed {
		logic       ovl;    // overlay level for this row
		apb_addr_t  addr;
		apb_data_t  wdata;
		apb_data_t  rdata;  // expected read back
		logic       err;    // expected pslverr
		logic       tcr;    // expected turbochipram
		logic       tk;     // expected turbokick
		logic       aga;
		logic [1:0] slow;
	} step_t;

	logic       clk;
	logic       reset;
	logic       rst_ext;
	logic       kbd_reset_n;
	logic       cpu_reset_n;
	logic       vsync_n;
	logic       ovl;
	logic       led_n;
	apb_req_t   apb_req;
	apb_rsp_t   apb_rsp;
	rtc_t       rtc;
	sys_cfg_t   cfg;
	logic       sys_reset;
	logic       cpu_reset_n_out;
	logic       rst_out;
	logic       init_b;
	logic       sample_en;
	logic       turbochipram;
	logic       turbokick;
	logic       aga;
	logic       ntsc;
	logic       pwr_led;
	logic [1:0] slow_config;

	step_t     steps [NUM_STEPS];
	int        errors;
	int        checks;
	int        seed;
	int        pulses;
	sys_cfg_t  exp_cfg;
	apb_data_t rdata;
	logic      err;
	logic      init_b_exp;  // mcu flag model, low after reset

	minimig_sysctl minimig_sysctl_inst (
		.clk            (clk),
		.reset          (reset),
		.rst_ext_i      (rst_ext),
		.kbd_reset_n_i  (kbd_reset_n),
		.cpu_reset_n_i  (cpu_reset_n),
		.vsync_n_i      (vsync_n),
		.ovl_i          (ovl),
		.led_n_i        (led_n),
		.apb_req_i      (apb_req),
		.apb_rsp_o      (apb_rsp),
		.rtc_i          (rtc),
		.cfg_o          (cfg),
		.sys_reset_o    (sys_reset),
		.cpu_reset_n_o  (cpu_reset_n_out),
		.rst_out_o      (rst_out),
		.init_b_o       (init_b),
		.sample_en_o    (sample_en),
		.turbochipram_o (turbochipram),
		.turbokick_o    (turbokick),
		.aga_o          (aga),
		.ntsc_o         (ntsc),
		.pwr_led_o      (pwr_led),
		.slow_config_o  (slow_config)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;  // 100 MHz
	end

	// --------------------
	// helpers
	// --------------------
	task check(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (act !== exp) begin
			$display("** Error at %0t ns: %s expected %h got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	// setup, access, then hold until pready
	task run_transfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
			output apb_data_t rd, output logic slverr);
		int n;
		@(posedge clk);
		apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
		@(posedge clk);
		apb_req.penable <= 1'b1;
		n = 0;
		@(negedge clk);
		while (!apb_rsp.pready && n < APB_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (!apb_rsp.pready) begin
			$display("APB transfer at offset %h got no pready in time", addr);
			errors++;
		end
		check("wait states", 1, n);  // exactly one
		rd     = apb_rsp.prdata;
		slverr = apb_rsp.pslverr;
		@(posedge clk);
		apb_req <= '0;
	endtask

	task apb_write(input apb_addr_t addr, input apb_data_t wdata, output logic slverr);
		apb_data_t unused;
		run_transfer(1'b1, addr, wdata, unused, slverr);
	endtask

	task apb_read(input apb_addr_t addr, output apb_data_t rd, output logic slverr);
		run_transfer(1'b0, addr, '0, rd, slverr);
	endtask

	task wait_sys_reset(input logic level);
		int n;
		n = 0;
		@(negedge clk);
		while (sys_reset !== level && n < RESET_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (sys_reset !== level) begin
			$display("sys_reset_o did not reach %0b in time", level);
			errors++;
		end
	endtask

	// one vsync low pulse, init_b must flip 2 cycles after the sampling edge
	task vsync_frame;
		@(posedge clk);
		vsync_n <= 1'b0;
		@(posedge clk);  // edge that samples low
		@(negedge clk);
		check("init_b_o", init_b_exp, init_b);
		@(negedge clk);
		check("init_b_o", init_b_exp, init_b);
		init_b_exp = ~init_b_exp;  // one toggle per falling edge
		@(negedge clk);
		check("init_b_o", init_b_exp, init_b);
		repeat (4) @(posedge clk);
		vsync_n <= 1'b1;
		repeat (6) @(negedge clk);
		check("init_b_o", init_b_exp, init_b);  // rising edge leaves it
	endtask

	// src 0 user, 1 keyboard, 2 external
	task reset_case(input int src, input logic ntsc_exp);
		logic slverr;
		if (src == 0) begin
			apb_write(REG_CTRL, 32'h3, slverr);  // usrrst, dim_n kept
		end else begin
			@(posedge clk);
			if (src == 1)
				kbd_reset_n <= 1'b0;
			else
				rst_ext <= 1'b1;
			@(negedge clk);
			check("sys_reset_o", 1'b0, sys_reset);
			@(negedge clk);
			check("sys_reset_o", 1'b1, sys_reset);  // one cycle later
		end
		wait_sys_reset(1'b1);
		check("cpu_reset_n_o", 1'b0, cpu_reset_n_out);
		check("rst_out_o", 1'b1, rst_out);
		vsync_frame;  // source still active, frame ignored
		check("sys_reset_o", 1'b1, sys_reset);
		if (src == 0) begin
			apb_write(REG_CTRL, 32'h2, slverr);
		end else begin
			@(posedge clk);
			kbd_reset_n <= 1'b1;
			rst_ext     <= 1'b0;
		end
		vsync_frame;
		check("sys_reset_o", 1'b1, sys_reset);  // one frame is not enough
		check("ntsc_o", ntsc_exp, ntsc);
		vsync_frame;
		wait_sys_reset(1'b0);
		check("cpu_reset_n_o", 1'b1, cpu_reset_n_out);
		check("rst_out_o", 1'b0, rst_out);
		check("ntsc_o", ntsc_exp, ntsc);
	endtask

	task led_test;
		logic hist [48];
		logic slverr;
		int   ones;
		@(posedge clk);
		led_n <= 1'b1;
		apb_write(REG_CTRL, 32'h0, slverr);  // dim_n low
		for (int i = 0; i < 48; i++) begin
			@(negedge clk);
			hist[i] = pwr_led;
		end
		for (int i = 0; i <= 32; i++) begin
			ones = 0;
			for (int j = 0; j < 16; j++)
				if (hist[i + j])
					ones++;
			check("pwr_led_o lit per 16", 1, ones);
		end
		@(posedge clk);
		led_n <= 1'b0;
		repeat (16) begin
			@(negedge clk);
			check("pwr_led_o", 1'b1, pwr_led);
		end
		apb_write(REG_CTRL, 32'h2, slverr);  // full brightness
		@(negedge clk);
		check("pwr_led_o", 1'b1, pwr_led);
		@(posedge clk);
		led_n <= 1'b1;
		repeat (16) begin
			@(negedge clk);
			check("pwr_led_o", 1'b0, pwr_led);
		end
	endtask

	// ovl, offset, write, read back, err, tcr, tk, aga, slow
	task load_steps;
		steps[0]  = '{1'b0, REG_MEMCFG, 32'h3, 32'h3, 1'b0, 1'b0, 1'b0, 1'b0, 2'd0};
		steps[1]  = '{1'b0, REG_CPUCFG, 32'h4, 32'h4, 1'b0, 1'b1, 1'b0, 1'b0, 2'd0};
		steps[2]  = '{1'b1, REG_CPUCFG, 32'hC, 32'hC, 1'b0, 1'b0, 1'b0, 1'b0, 2'd0};
		steps[3]  = '{1'b0, REG_CPUCFG, 32'hC, 32'hC, 1'b0, 1'b1, 1'b1, 1'b0, 2'd0};
		steps[4]  = '{1'b0, REG_MEMCFG, 32'h4A, 32'h4A, 1'b0, 1'b0, 1'b1, 1'b0, 2'd2};
		steps[5]  = '{1'b0, REG_CHIPCFG, 32'h10, 32'h10, 1'b0, 1'b0, 1'b1, 1'b1, 2'd2};
		steps[6]  = '{1'b0, REG_MEMCFG, 32'hFFFF_FFFF, 32'h7F, 1'b0, 1'b1, 1'b1, 1'b1, 2'd3};
		steps[7]  = '{1'b1, REG_FLOPCFG, 32'h5, 32'h5, 1'b0, 1'b0, 1'b0, 1'b1, 2'd3};
		steps[8]  = '{1'b1, REG_CHIPCFG, 32'hFFFF_FFEF, 32'hF, 1'b0, 1'b0, 1'b0, 1'b0, 2'd3};
		steps[9]  = '{1'b0, REG_CPUCFG, 32'h8, 32'h8, 1'b0, 1'b0, 1'b1, 1'b0, 2'd3};
		steps[10] = '{1'b0, REG_CTRL, 32'h2, 32'h2, 1'b0, 1'b0, 1'b1, 1'b0, 2'd3};
		steps[11] = '{1'b0, 8'h14, 32'h55, 32'h0, 1'b1, 1'b0, 1'b1, 1'b0, 2'd3};
		steps[12] = '{1'b0, 8'h41, 32'h1, 32'h0, 1'b1, 1'b0, 1'b1, 1'b0, 2'd3};  // unaligned
		steps[13] = '{1'b1, 8'hFC, 32'hFFFF_FFFF, 32'h0, 1'b1, 1'b0, 1'b0, 1'b0, 2'd3};
		steps[14] = '{1'b0, REG_CHIPCFG, 32'h0, 32'h0, 1'b0, 1'b0, 1'b1, 1'b0, 2'd3};
	endtask

	// --------------------
	// main sequence
	// --------------------
	initial begin
		errors      = 0;
		checks      = 0;
		seed        = 95;
		init_b_exp  = 1'b0;
		reset       = 1'b1;
		rst_ext     = 1'b0;
		kbd_reset_n = 1'b1;
		cpu_reset_n = 1'b1;
		vsync_n     = 1'b1;
		ovl         = 1'b0;
		led_n       = 1'b1;
		apb_req     = '0;
		rtc         = {$random(seed), $random(seed)};
		exp_cfg     = '{mem: 7'h7F, chip: 5'h00, flop: 4'h5, cpu: 4'h8};
		load_steps;

		repeat (15) @(posedge clk);
		@(negedge clk);  // still in reset
		check("pready", 1'b0, apb_rsp.pready);
		check("pslverr", 1'b0, apb_rsp.pslverr);
		check("cfg_o", '0, cfg);
		check("sample_en_o", 1'b0, sample_en);
		check("init_b_o", 1'b0, init_b);
		check("sys_reset_o", 1'b1, sys_reset);
		@(posedge clk);
		reset <= 1'b0;

		// sample enable rate from the first cycle out of reset
		pulses = 0;
		for (int i = 0; i < AUDIO_CYCLES; i++) begin
			@(negedge clk);
			if (sample_en)
				pulses++;
		end
		check("sample_en_o pulses", longint'(AUDIO_CYCLES) * AUDIO_RATE_HZ / SYS_CLK_HZ, pulses);

		// power-on hold, two frames
		vsync_frame;
		check("sys_reset_o", 1'b1, sys_reset);
		vsync_frame;
		wait_sys_reset(1'b0);

		for (int i = 0; i < NUM_STEPS; i++) begin
			@(posedge clk);
			ovl <= steps[i].ovl;
			apb_write(steps[i].addr, steps[i].wdata, err);
			check("pslverr", steps[i].err, err);
			apb_read(steps[i].addr, rdata, err);
			check("prdata", steps[i].rdata, rdata);
			check("pslverr", steps[i].err, err);
			@(negedge clk);
			check("turbochipram_o", steps[i].tcr, turbochipram);
			check("turbokick_o", steps[i].tk, turbokick);
			check("aga_o", steps[i].aga, aga);
			check("slow_config_o", steps[i].slow, slow_config);
		end
		check("cfg_o", exp_cfg, cfg);

		// rtc words, one nibble each
		for (int n = 0; n < 16; n++) begin
			apb_read(REG_RTC_BASE + apb_addr_t'(4 * n), rdata, err);
			check("prdata rtc", rtc[4 * n +: 4], rdata);
			check("pslverr", 1'b0, err);
		end
		apb_write(REG_RTC_BASE + 8'h08, 32'hF, err);
		check("pslverr", 1'b1, err);  // read only
		apb_read(REG_RTC_BASE + 8'h08, rdata, err);
		check("prdata rtc", rtc[11:8], rdata);
		check("cfg_o", exp_cfg, cfg);

		// ntsc only follows the config through a reset
		apb_write(REG_CHIPCFG, 32'h2, err);
		repeat (4) @(negedge clk);
		check("ntsc_o", 1'b0, ntsc);
		reset_case(0, 1'b1);
		apb_write(REG_CHIPCFG, 32'h0, err);
		reset_case(1, 1'b0);
		apb_write(REG_CHIPCFG, 32'h12, err);
		reset_case(2, 1'b1);

		// cpu held in reset by itself
		@(posedge clk);
		cpu_reset_n <= 1'b0;
		@(negedge clk);
		check("rst_out_o", 1'b1, rst_out);
		check("sys_reset_o", 1'b0, sys_reset);
		check("cpu_reset_n_o", 1'b1, cpu_reset_n_out);
		@(posedge clk);
		cpu_reset_n <= 1'b1;
		@(negedge clk);
		check("rst_out_o", 1'b0, rst_out);

		led_test;

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

/* minimig_sysctl.f */
design/sys_cfg_pkg.sv
design/sys_timing_pkg.sv
design/cfg_regs.sv
design/frame_sync.sv
design/reset_seq.sv
design/audio_tick.sv
design/mode_flags.sv
design/minimig_sysctl.sv
bench/tb_minimig_sysctl.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
	--top-module tb_minimig_sysctl \
	-f minimig_sysctl.f \
	-o tb_sim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Regression failed" sim.log; then
	exit 1
fi
if ! grep -q "Regression passed" sim.log; then
	echo "no result line found in sim.log"
	exit 1
fi
exit 0
